//--- lenet_mac_top.f
+incdir+rtl
rtl/lenet_mac_pkg.sv
rtl/approx_mult_8x8.sv
rtl/mac_cfg_regs.sv
rtl/mac_datapath.sv
rtl/lenet_mac_top.sv
sim/lenet_mac_checker.sv
sim/lenet_mac_tb.sv

//--- rtl/approx_mult_8x8.sv
`timescale 1ns/1ns
`include "lenet_mac_params.svh"

module approx_mult_8x8 (
    input  logic [`MAC_DATA_W-1:0] x,
    input  logic [`MAC_DATA_W-1:0] y,
    output logic [`MAC_PROD_W-1:0] z
);

    logic [`MAC_DATA_W-1:0] pp [`MAC_DATA_W];  // pp[i] has weight 2**i.
    logic [12:0]            cw [5];            // sparse correction words.

    always_comb begin
        for (int i = 0; i < `MAC_DATA_W; i++) begin
            pp[i] = y & {`MAC_DATA_W{x[i]}};
        end
    end

    // lower rows never reach the sum directly.
    // selected bit pairs of rows 0 to 5 are merged into five words instead.
    always_comb begin
        cw[0] = '0;
        cw[0][5]  = pp[2][2] ^ pp[3][1];
        cw[0][6]  = pp[0][5] | pp[1][4];
        cw[0][7]  = pp[4][2] & pp[5][1];
        cw[0][8]  = pp[0][7] ^ pp[1][6];
        cw[0][9]  = pp[2][7] | pp[3][6];
        cw[0][10] = pp[3][7];
        cw[0][11] = pp[4][7] | pp[5][6];
        cw[0][12] = pp[4][7] & pp[5][6];
    end

    always_comb begin
        cw[1] = '0;
        cw[1][6]  = pp[0][6] ^ pp[1][5];
        cw[1][7]  = pp[4][3] | pp[5][2];
        cw[1][8]  = pp[2][5] | pp[3][4];
        cw[1][9]  = pp[4][4] & pp[5][3];
        cw[1][10] = pp[4][5] & pp[5][4];
        cw[1][12] = pp[5][7];
    end

    always_comb begin
        cw[2] = '0;
        cw[2][6]  = pp[2][3] | pp[3][2];
        cw[2][8]  = pp[2][6] & pp[3][5];
        cw[2][9]  = pp[4][5] ^ pp[5][4];
        cw[2][10] = pp[4][6] & pp[5][5];
    end

    always_comb begin
        cw[3] = '0;
        cw[3][6]  = pp[4][2] ^ pp[5][1];
        cw[3][8]  = pp[2][6] | pp[3][5];
        cw[3][10] = pp[4][6] ^ pp[5][5];
    end

    always_comb begin
        cw[4] = '0;
        cw[4][8] = pp[4][4] ^ pp[5][3];  // lone term of the last word.
    end

    // rows 6 and 7 are kept exact.
    assign z = {2'b00, pp[6], 6'b0}
             + {1'b0, pp[7], 7'b0}
             + {3'b000, cw[0]}
             + {3'b000, cw[1]}
             + {3'b000, cw[2]}
             + {3'b000, cw[3]}
             + {3'b000, cw[4]};

endmodule

//--- rtl/lenet_mac_params.svh
`ifndef LENET_MAC_PARAMS_SVH
`define LENET_MAC_PARAMS_SVH

// pixel and weight width.
`define MAC_DATA_W 8

// full product of two data words.
`define MAC_PROD_W 16

`define MAC_ACC_W 24 // accumulator and result, signed.

// register port word.
`define MAC_CFG_W 16

// register map.
`define MAC_ADDR_CTRL 2'd0
`define MAC_ADDR_BIAS 2'd1

`endif

//--- rtl/lenet_mac_pkg.sv
`include "lenet_mac_params.svh"

package lenet_mac_pkg;

    // one pixel and weight pair of a kernel window.
    typedef struct packed {
        logic [`MAC_DATA_W-1:0] pixel;
        logic [`MAC_DATA_W-1:0] weight;
        logic                   last;   // closes the window.
    } mac_beat_t;

    // control register layout, approx_en sits in bit 0.
    typedef struct packed {
        logic [`MAC_CFG_W-6:0] spare;
        logic [2:0]            shift;     // arithmetic right shift of the result.
        logic                  relu_en;
        logic                  approx_en;
    } mac_ctrl_t;

    // the write word means control fields at one address and bias at the other.
    typedef union packed {
        mac_ctrl_t                    ctrl;
        logic signed [`MAC_CFG_W-1:0] bias;
    } cfg_word_u;

    typedef struct packed {
        mac_ctrl_t                    ctrl;
        logic signed [`MAC_CFG_W-1:0] bias;
    } mac_cfg_t;

    typedef struct packed {
        logic signed [`MAC_ACC_W-1:0] value;
        logic [7:0]                   count;  // beats in the window.
    } mac_result_t;

endpackage

//--- rtl/lenet_mac_top.sv
`timescale 1ns/1ns
`include "lenet_mac_params.svh"

module lenet_mac_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       in_valid,
    output logic                       in_ready,
    input  lenet_mac_pkg::mac_beat_t   in_beat,

    output logic                       out_valid,
    input  logic                       out_ready,
    output lenet_mac_pkg::mac_result_t out_result,

    input  logic                       cfg_we,
    input  logic [1:0]                 cfg_addr,
    input  logic [`MAC_CFG_W-1:0]      cfg_wdata,
    output logic [`MAC_CFG_W-1:0]      cfg_rdata
);

    lenet_mac_pkg::mac_cfg_t cfg;  // live register settings.

    mac_cfg_regs regs_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

    // the multiplier sits inside the datapath.
    mac_datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .cfg        (cfg)
    );

endmodule

//--- rtl/mac_cfg_regs.sv
`timescale 1ns/1ns
`include "lenet_mac_params.svh"

module mac_cfg_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_we,
    input  logic [1:0]              cfg_addr,
    input  logic [`MAC_CFG_W-1:0]   cfg_wdata,
    output logic [`MAC_CFG_W-1:0]   cfg_rdata,
    output lenet_mac_pkg::mac_cfg_t cfg
);

    lenet_mac_pkg::cfg_word_u     wr_word;
    lenet_mac_pkg::cfg_word_u     rd_word;
    lenet_mac_pkg::mac_ctrl_t     wr_ctrl;
    lenet_mac_pkg::mac_ctrl_t     ctrl_q;
    logic signed [`MAC_CFG_W-1:0] bias_q;

    assign wr_word = cfg_wdata;

    // spare bits are dropped on the way in.
    always_comb begin
        wr_ctrl       = wr_word.ctrl;
        wr_ctrl.spare = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= '0;
            bias_q <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                `MAC_ADDR_CTRL: ctrl_q <= wr_ctrl;
                `MAC_ADDR_BIAS: bias_q <= wr_word.bias;
                default: ;  // unmapped.
            endcase
        end
    end

    // read-back, unmapped addresses return zero.
    always_comb begin
        rd_word = '0;
        case (cfg_addr)
            `MAC_ADDR_CTRL: rd_word.ctrl = ctrl_q;
            `MAC_ADDR_BIAS: rd_word.bias = bias_q;
            default: ;
        endcase
    end

    assign cfg_rdata = rd_word;

    assign cfg.ctrl = ctrl_q;
    assign cfg.bias = bias_q;

endmodule

//--- rtl/mac_datapath.sv
`timescale 1ns/1ns
`include "lenet_mac_params.svh"

module mac_datapath (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  lenet_mac_pkg::mac_beat_t   in_beat,
    output logic                       out_valid,
    input  logic                       out_ready,
    output lenet_mac_pkg::mac_result_t out_result,
    input  lenet_mac_pkg::mac_cfg_t    cfg
);

    // accepted beat with the settings it was accepted under.
    lenet_mac_pkg::mac_beat_t     beat_q;
    lenet_mac_pkg::mac_cfg_t      beat_cfg_q;
    logic                         beat_valid;
    logic                         in_fire;

    logic [`MAC_PROD_W-1:0]       approx_prod;
    logic [`MAC_PROD_W-1:0]       exact_prod;

    // stage 1, registered product.
    logic                         s1_valid;
    logic                         s1_last;
    logic [`MAC_PROD_W-1:0]       s1_prod;
    lenet_mac_pkg::mac_cfg_t      s1_cfg;

    // stage 2, accumulator.
    logic [`MAC_ACC_W-1:0]        acc_q;
    logic [7:0]                   cnt_q;
    logic [`MAC_ACC_W-1:0]        acc_sum;
    logic signed [`MAC_ACC_W-1:0] biased;
    logic signed [`MAC_ACC_W-1:0] shifted;
    logic signed [`MAC_ACC_W-1:0] final_val;

    // hold off input until a closing beat has left the pipe and its result is taken.
    assign in_ready = !(beat_valid && beat_q.last) && !(s1_valid && s1_last) && !out_valid;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= in_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            beat_q     <= in_beat;
            beat_cfg_q <= cfg;  // sampled at acceptance.
        end
    end

    approx_mult_8x8 mult_i (
        .x (beat_q.pixel),
        .y (beat_q.weight),
        .z (approx_prod)
    );

    assign exact_prod = beat_q.pixel * beat_q.weight;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= beat_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            s1_prod <= beat_cfg_q.ctrl.approx_en ? approx_prod : exact_prod;
            s1_last <= beat_q.last;
            s1_cfg  <= beat_cfg_q;
        end
    end

    // bias, then shift, then relu.
    always_comb begin
        acc_sum   = acc_q + {{(`MAC_ACC_W-`MAC_PROD_W){1'b0}}, s1_prod};
        biased    = $signed(acc_sum)
                  + $signed({{(`MAC_ACC_W-`MAC_CFG_W){s1_cfg.bias[`MAC_CFG_W-1]}}, s1_cfg.bias});
        shifted   = biased >>> s1_cfg.ctrl.shift;
        final_val = (s1_cfg.ctrl.relu_en && shifted < 0) ? '0 : shifted;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q     <= '0;
            cnt_q     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (s1_valid) begin
                if (s1_last) begin
                    acc_q     <= '0;    // next window starts clean.
                    cnt_q     <= '0;
                    out_valid <= 1'b1;
                end else begin
                    acc_q <= acc_sum;
                    cnt_q <= cnt_q + 8'd1;
                end
            end
        end
    end

    // the register is always empty here since in_ready kept new beats out.
    always_ff @(posedge clk) begin
        if (s1_valid && s1_last) begin
            out_result.value <= final_val;
            out_result.count <= cnt_q + 8'd1;
        end
    end

endmodule

//--- sim/lenet_mac_checker.sv
`timescale 1ns/1ns
`include "lenet_mac_params.svh"

module lenet_mac_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       in_valid,
    input logic                       in_ready,
    input lenet_mac_pkg::mac_beat_t   in_beat,
    input logic                       out_valid,
    input logic                       out_ready,
    input lenet_mac_pkg::mac_result_t out_result,
    input logic                       cfg_we,
    input logic [1:0]                 cfg_addr,
    input logic [`MAC_CFG_W-1:0]      cfg_wdata,
    input logic [`MAC_CFG_W-1:0]      cfg_rdata
);

    string test_name = "none";
    int    mismatch_count = 0;
    int    protocol_count = 0;
    int    pending = 0;

    lenet_mac_pkg::mac_result_t exp_q[$];
    string                      name_q[$];
    lenet_mac_pkg::mac_result_t held_result;
    logic [4:0]                 ctrl_sh;   // shift, relu_en, approx_en.
    logic signed [15:0]         bias_sh;
    logic [23:0]                win_sum;
    logic [7:0]                 win_cnt;
    int                         cycle;
    int                         last_accept;
    logic                       held;
    logic                       prev_valid;

    function automatic int weighted(logic b, int w);
        return b ? (1 << w) : 0;
    endfunction

    // rows 6 and 7 exact, selected low-row bit pairs merged at fixed weights.
    function automatic logic [15:0] approx_mult(logic [7:0] x, logic [7:0] y);
        logic [7:0][7:0] pp;
        int              z;
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
        z = (int'(pp[6]) << 6) + (int'(pp[7]) << 7);
        z += weighted(pp[2][2] ^ pp[3][1], 5);
        z += weighted(pp[0][5] | pp[1][4], 6) + weighted(pp[0][6] ^ pp[1][5], 6);
        z += weighted(pp[2][3] | pp[3][2], 6) + weighted(pp[4][2] ^ pp[5][1], 6);
        z += weighted(pp[4][2] & pp[5][1], 7) + weighted(pp[4][3] | pp[5][2], 7);
        z += weighted(pp[0][7] ^ pp[1][6], 8) + weighted(pp[2][5] | pp[3][4], 8);
        z += weighted(pp[2][6] & pp[3][5], 8) + weighted(pp[2][6] | pp[3][5], 8);
        z += weighted(pp[4][4] ^ pp[5][3], 8);
        z += weighted(pp[2][7] | pp[3][6], 9) + weighted(pp[4][4] & pp[5][3], 9);
        z += weighted(pp[4][5] ^ pp[5][4], 9);
        z += weighted(pp[3][7], 10) + weighted(pp[4][5] & pp[5][4], 10);
        z += weighted(pp[4][6] & pp[5][5], 10) + weighted(pp[4][6] ^ pp[5][5], 10);
        z += weighted(pp[4][7] | pp[5][6], 11);
        z += weighted(pp[4][7] & pp[5][6], 12) + weighted(pp[5][7], 12);
        return z[15:0];
    endfunction

    function automatic logic signed [23:0] window_result(logic [23:0] sum,
            logic signed [15:0] bias, logic [2:0] shift, logic relu);
        logic signed [23:0] v;
        v = sum + {{8{bias[15]}}, bias};
        v = v >>> shift;
        if (relu && v < 0) begin
            v = '0;
        end
        return v;
    endfunction

    always @(posedge clk) begin
        logic [15:0]                prod;
        lenet_mac_pkg::mac_result_t exp_r;
        logic [15:0]                exp_rdata;
        if (rst) begin
            exp_q.delete();
            name_q.delete();
            {ctrl_sh, bias_sh, win_sum, win_cnt} = '0;
            {held, prev_valid} = 2'b00;
            cycle = 0;
            last_accept = 0;
        end else begin
            cycle++;
            if (cycle == 1 && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
                protocol_count++;
                $display("after reset out_valid is not low or in_ready is not high");
            end
            if (held && !out_valid) begin
                protocol_count++;
                $display("out_valid dropped before the result was taken");
            end else if (held && out_result !== held_result) begin
                protocol_count++;
                $display("out_result changed while out_valid was held");
            end
            if (out_valid && in_ready) begin
                protocol_count++;
                $display("in_ready was high while the result register was full");
            end
            if (out_valid && !prev_valid && cycle - 1 - last_accept != 2) begin
                protocol_count++;
                $display("out_valid rose %0d cycles after the last beat, not 2",
                         cycle - 1 - last_accept);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_count++;
                    $display("a result came out with no window pending");
                end else begin
                    exp_r = exp_q.pop_front();
                    if (out_result !== exp_r) begin
                        mismatch_count++;
                        $display("Mismatch %s: expected %0d (count %0d) actual %0d (count %0d)",
                                 name_q[0], exp_r.value, exp_r.count,
                                 out_result.value, out_result.count);
                    end
                    void'(name_q.pop_front());
                end
            end
            // control reads back its fields with spare bits zero.
            case (cfg_addr)
                `MAC_ADDR_CTRL: exp_rdata = {11'd0, ctrl_sh};
                `MAC_ADDR_BIAS: exp_rdata = bias_sh;
                default:        exp_rdata = '0;
            endcase
            if (cfg_rdata !== exp_rdata) begin
                mismatch_count++;
                $display("Mismatch %s: register %0d expected %h actual %h",
                         test_name, cfg_addr, exp_rdata, cfg_rdata);
            end
            held        = out_valid && !out_ready;
            held_result = out_result;
            prev_valid  = out_valid;
            if (in_valid && in_ready) begin
                prod = ctrl_sh[0] ? approx_mult(in_beat.pixel, in_beat.weight)
                                  : in_beat.pixel * in_beat.weight;
                win_sum += prod;
                win_cnt++;
                if (in_beat.last) begin  // window closes with this beat's settings.
                    exp_r.value = window_result(win_sum, bias_sh, ctrl_sh[4:2], ctrl_sh[1]);
                    exp_r.count = win_cnt;
                    exp_q.push_back(exp_r);
                    name_q.push_back(test_name);
                    last_accept = cycle;
                    win_sum = '0;
                    win_cnt = '0;
                end
            end
            if (cfg_we && cfg_addr == `MAC_ADDR_CTRL) begin
                ctrl_sh = cfg_wdata[4:0];
            end else if (cfg_we && cfg_addr == `MAC_ADDR_BIAS) begin
                bias_sh = cfg_wdata;
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- sim/lenet_mac_tb.sv
`timescale 1ns/1ns
`include "lenet_mac_params.svh"

module lenet_mac_tb;

    localparam int TOTAL_BEATS = 4*25 + 16 + 3*25 + 32*9 + 25 + 3*10;
    localparam int LIMIT = TOTAL_BEATS*40 + 1000;  // cycles.

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    lenet_mac_pkg::mac_beat_t   in_beat;
    logic                       out_valid;
    logic                       out_ready;
    lenet_mac_pkg::mac_result_t out_result;
    logic                       cfg_we;
    logic [1:0]                 cfg_addr;
    logic [`MAC_CFG_W-1:0]      cfg_wdata;
    logic [`MAC_CFG_W-1:0]      cfg_rdata;

    int         seed = 32'h16b7;
    int         bp_mode = 0;     // 0 ready, 1 random stalls, 2 held low.
    int         stall_left = 0;
    logic [7:0] corners [4] = '{8'd0, 8'd255, 8'd128, 8'd1};

    always #10 clk = ~clk;

    lenet_mac_top dut_i (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
        .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    lenet_mac_checker chk_i (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
        .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    function automatic logic [15:0] ctrl_word(logic approx, logic relu, logic [2:0] shift);
        lenet_mac_pkg::mac_ctrl_t c;
        c           = '0;
        c.approx_en = approx;
        c.relu_en   = relu;
        c.shift     = shift;
        return c;
    endfunction

    // all tasks start and end on a falling edge.
    task automatic write_reg(logic [1:0] addr, logic [15:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic read_reg(logic [1:0] addr);
        cfg_addr = addr;
        @(negedge clk);
    endtask

    task automatic send_beat(logic [7:0] pixel, logic [7:0] weight, logic last);
        in_valid       = 1'b1;
        in_beat.pixel  = pixel;
        in_beat.weight = weight;
        in_beat.last   = last;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);  // taken at the rising edge just passed.
        in_valid = 1'b0;
    endtask

    task automatic send_window(int n, logic [7:0] mask);
        for (int i = 0; i < n; i++) begin
            send_beat($random(seed) & mask, $random(seed) & mask, i == n - 1);
        end
    endtask

    task automatic wait_results();
        while (chk_i.pending != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_mode == 2) begin
                out_ready = 1'b0;
            end else if (bp_mode == 1 && stall_left > 0) begin
                out_ready = 1'b0;
                stall_left--;
            end else begin
                out_ready = 1'b1;
                if (bp_mode == 1 && ($random(seed) & 3) == 0) begin
                    stall_left = ($random(seed) & 15) + 1;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_beat   = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        chk_i.test_name = "registers";
        read_reg(`MAC_ADDR_CTRL);
        read_reg(`MAC_ADDR_BIAS);
        write_reg(`MAC_ADDR_CTRL, 16'hffee);  // spare bits set on the way in.
        read_reg(`MAC_ADDR_CTRL);
        write_reg(`MAC_ADDR_BIAS, 16'h8123);
        read_reg(`MAC_ADDR_BIAS);
        read_reg(2'd2);
        write_reg(`MAC_ADDR_CTRL, 16'h0000);
        write_reg(`MAC_ADDR_BIAS, 16'h0000);

        chk_i.test_name = "exact";
        repeat (4) send_window(25, 8'hff);
        wait_results();

        chk_i.test_name = "approx";
        write_reg(`MAC_ADDR_CTRL, ctrl_word(1'b1, 1'b0, 3'd0));
        for (int i = 0; i < 16; i++) begin
            send_beat(corners[i / 4], corners[i % 4], i == 15);
        end
        bp_mode = 1;
        repeat (3) send_window(25, 8'hff);
        bp_mode = 0;
        wait_results();

        // small windows stay below the bias, full-range ones end up above it.
        chk_i.test_name = "bias_shift_relu";
        write_reg(`MAC_ADDR_BIAS, -16'sd3000);
        for (int s = 0; s < 8; s++) begin
            for (int r = 0; r < 2; r++) begin
                write_reg(`MAC_ADDR_CTRL, ctrl_word(s[0], r[0], s[2:0]));
                send_window(9, 8'h0f);
                send_window(9, 8'hff);
            end
        end
        wait_results();

        chk_i.test_name = "backpressure";
        write_reg(`MAC_ADDR_CTRL, 16'h0000);
        write_reg(`MAC_ADDR_BIAS, 16'h0000);
        bp_mode = 2;
        @(negedge clk);
        send_window(25, 8'hff);
        repeat (4) @(negedge clk);  // result held while input stays blocked.
        bp_mode = 1;
        repeat (3) send_window(10, 8'hff);
        bp_mode = 0;
        wait_results();
        repeat (4) @(negedge clk);

        $display("error counts: %0d mismatch, %0d protocol",
                 chk_i.mismatch_count, chk_i.protocol_count);
        if (chk_i.mismatch_count + chk_i.protocol_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
